//--- rv32_core.f
rtl/rv_pkg.sv
rtl/register_file.sv
rtl/fetch_unit.sv
rtl/execute_unit.sv
rtl/load_store_unit.sv
rtl/rv32_core.sv
verification/wb_mem_model.sv
verification/tb_rv32_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv32_core
FILELIST  ?= rv32_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

# $fatal in the testbench gives a non-zero exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- verification/tb_rv32_core.sv
`timescale 1ns/1ps

module tb_rv32_core;

  localparam int          PROG_WORDS   = 37;
  localparam int          WRITES       = 16;
  localparam int          WAIT_LIMIT   = 100;  // cycles allowed per wait
  localparam int          QUIET_CYCLES = 60;
  localparam logic [31:0] BOOT_PC      = 32'h8000_0000;
  localparam logic [31:0] HALT_PC      = 32'h8000_008c;
  localparam logic [31:0] DATA_WORD    = 32'h8c7f_e5a4;  // lives at BOOT_PC + 0x100

  typedef struct packed {
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
  } bus_write_t;

  // expected data-bus writes, in program order
  localparam bus_write_t EXPECTED [WRITES] = '{
    '{32'h8000_0180, 32'hffff_fffb, 4'hf},  // addi
    '{32'h8000_0184, 32'h1234_5000, 4'hf},  // lui
    '{32'h8000_0188, 32'h7fff_f01c, 4'hf},  // auipc
    '{32'h8000_018c, 32'h0000_0000, 4'hf},  // x0 untouched
    '{32'h8000_0190, 32'h8000_0030, 4'hf},  // jal link
    '{32'h8000_0194, 32'h8000_0034, 4'hf},  // jal target pc
    '{32'h8000_0198, 32'h8000_0048, 4'hf},  // jalr link
    '{32'h8000_019c, 32'h8000_004c, 4'hf},  // jalr target pc, bit 0 cleared
    '{32'h8000_01a0, 32'hffff_ff8c, 4'hf},  // lb lane 3
    '{32'h8000_01a4, 32'h0000_00e5, 4'hf},  // lbu lane 1
    '{32'h8000_01a8, 32'hffff_8c7f, 4'hf},  // lh upper half
    '{32'h8000_01ac, 32'h0000_e5a4, 4'hf},  // lhu lower half
    '{32'h8000_01b0, 32'h8c7f_e5a4, 4'hf},  // lw
    '{32'h8000_01b4, 32'ha4a4_a4a4, 4'h2},  // sb at offset 1
    '{32'h8000_01b8, 32'he5a4_e5a4, 4'hc},  // sh at offset 2
    '{32'h8000_01bc, 32'h8c7f_8c7f, 4'h3}   // sh at offset 0
  };

  logic        clk;
  logic        reset;
  logic        ibus_cyc;
  logic        ibus_stb;
  logic [31:0] ibus_adr;
  logic [31:0] ibus_dat_r;
  logic        ibus_ack;
  logic        dbus_cyc;
  logic        dbus_stb;
  logic        dbus_we;
  logic [31:0] dbus_adr;
  logic [3:0]  dbus_sel;
  logic [31:0] dbus_dat_w;
  logic [31:0] dbus_dat_r;
  logic        dbus_ack;
  logic [31:0] pc;
  logic        halt;

  rv32_core i_dut (.*);

  wb_mem_model i_mem (.*);

  function automatic logic [31:0] imm_op(int opc, int rd, int f3, int rs1, int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] store_op(int f3, int rs2, int rs1, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] upper_op(int opc, int rd, int imm);
    return {imm[19:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] jump_op(int rd, int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      stop_run($sformatf("mismatch at %0d ns: %s is %h, expected %h", $time, what, got, want));
    end
  endtask

  task automatic load_memory();
    logic [31:0] prog [PROG_WORDS];
    prog = '{
      upper_op('h37, 1, 'h80000),   // lui   x1, 0x80000
      imm_op('h13, 1, 0, 1, 256),   // addi  x1, x1, 256
      imm_op('h13, 2, 0, 1, 128),   // addi  x2, x1, 128
      imm_op('h13, 3, 0, 0, -5),    // addi  x3, x0, -5
      store_op(2, 3, 2, 0),
      upper_op('h37, 4, 'h12345),   // lui   x4, 0x12345
      store_op(2, 4, 2, 4),
      upper_op('h17, 5, 'hfffff),   // auipc x5, 0xfffff
      store_op(2, 5, 2, 8),
      imm_op('h13, 0, 0, 0, 77),    // addi  x0, x0, 77
      store_op(2, 0, 2, 12),
      jump_op(6, 8),                // jal   x6, +8
      store_op(2, 3, 2, 0),         // skipped
      upper_op('h17, 7, 0),         // auipc x7, 0
      store_op(2, 6, 2, 16),
      store_op(2, 7, 2, 20),
      imm_op('h13, 8, 0, 1, -180),  // addi  x8, x1, -180
      imm_op('h67, 9, 0, 8, 1),     // jalr  x9, 1(x8), odd target
      store_op(2, 3, 2, 0),         // skipped
      upper_op('h17, 10, 0),        // auipc x10, 0
      store_op(2, 9, 2, 24),
      store_op(2, 10, 2, 28),
      imm_op('h03, 11, 0, 1, 3),    // lb    x11, 3(x1)
      store_op(2, 11, 2, 32),
      imm_op('h03, 12, 4, 1, 1),    // lbu   x12, 1(x1)
      store_op(2, 12, 2, 36),
      imm_op('h03, 13, 1, 1, 2),    // lh    x13, 2(x1)
      store_op(2, 13, 2, 40),
      imm_op('h03, 14, 5, 1, 0),    // lhu   x14, 0(x1)
      store_op(2, 14, 2, 44),
      imm_op('h03, 15, 2, 1, 0),    // lw    x15, 0(x1)
      store_op(2, 15, 2, 48),
      store_op(0, 15, 2, 53),       // sb    x15, 53(x2)
      store_op(1, 15, 2, 58),       // sh    x15, 58(x2)
      store_op(1, 13, 2, 60),       // sh    x13, 60(x2)
      32'h0010_0073,                // ebreak
      store_op(2, 3, 2, 0)          // past the halt
    };
    for (int i = 0; i < 128; i++) begin
      i_mem.mem[i] = BOOT_PC + 32'(4 * i);  // fill word holds its own address
    end
    for (int i = 0; i < PROG_WORDS; i++) begin
      i_mem.mem[i] = prog[i];
    end
    i_mem.mem[64] = DATA_WORD;
  endtask

  task automatic wait_for_write(input int index);
    int cycles = 0;
    while (i_mem.log_count <= index) begin
      if (cycles == WAIT_LIMIT) begin
        stop_run($sformatf("timeout waiting for data-bus write %0d", index));
      end
      cycles++;
      @(negedge clk);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    int cycles;
    reset = 1'b1;
    load_memory();
    repeat (4) begin
      @(posedge clk);
      #1;
      check_value("ibus_cyc in reset", 32'(ibus_cyc), 32'd0);
      check_value("ibus_stb in reset", 32'(ibus_stb), 32'd0);
      check_value("dbus_cyc in reset", 32'(dbus_cyc), 32'd0);
      check_value("dbus_stb in reset", 32'(dbus_stb), 32'd0);
      check_value("halt in reset", 32'(halt), 32'd0);
      check_value("pc in reset", pc, BOOT_PC);
    end
    reset = 1'b0;

    cycles = 0;
    while (ibus_cyc !== 1'b1) begin
      if (cycles == WAIT_LIMIT) begin
        stop_run("timeout waiting for the first instruction fetch");
      end
      cycles++;
      @(negedge clk);
    end
    check_value("first fetch stb", 32'(ibus_stb), 32'd1);
    check_value("first fetch address", ibus_adr, BOOT_PC);

    for (int k = 0; k < WRITES; k++) begin
      wait_for_write(k);
      check_value($sformatf("write %0d address", k), i_mem.log_adr[k], EXPECTED[k].adr);
      check_value($sformatf("write %0d data", k), i_mem.log_dat[k], EXPECTED[k].dat);
      check_value($sformatf("write %0d select", k), 32'(i_mem.log_sel[k]),
                  32'(EXPECTED[k].sel));
    end

    cycles = 0;
    while (halt !== 1'b1) begin
      if (cycles == WAIT_LIMIT) begin
        stop_run("timeout waiting for halt after ebreak");
      end
      cycles++;
      @(negedge clk);
    end
    check_value("pc at halt", pc, HALT_PC);

    // core must stay quiet once halted
    for (int k = 0; k < QUIET_CYCLES; k++) begin
      @(negedge clk);
      check_value("ibus_cyc after halt", 32'(ibus_cyc), 32'd0);
      check_value("ibus_stb after halt", 32'(ibus_stb), 32'd0);
      check_value("halt after ebreak", 32'(halt), 32'd1);
    end
    check_value("write count after halt", i_mem.log_count, WRITES);

    $display("** PASS **");
    $finish;
  end

endmodule

//--- verification/wb_mem_model.sv
`timescale 1ns/1ps

module wb_mem_model (
  input  logic        clk,
  input  logic        reset,
  input  logic        ibus_cyc,
  input  logic        ibus_stb,
  input  logic [31:0] ibus_adr,
  output logic [31:0] ibus_dat_r,
  output logic        ibus_ack,
  input  logic        dbus_cyc,
  input  logic        dbus_stb,
  input  logic        dbus_we,
  input  logic [31:0] dbus_adr,
  input  logic [3:0]  dbus_sel,
  input  logic [31:0] dbus_dat_w,
  output logic [31:0] dbus_dat_r,
  output logic        dbus_ack
);

  logic [31:0] mem [0:127];  // 512 bytes, aliased over the address space
  logic [31:0] log_adr [0:31];
  logic [31:0] log_dat [0:31];
  logic [3:0]  log_sel [0:31];
  int          log_count;
  logic [31:0] lfsr = 32'h91d8_0190;
  logic        i_busy;
  logic        d_busy;
  logic [1:0]  i_wait;
  logic [1:0]  d_wait;

  // right-shift Galois LFSR, one step per wait-count bit
  function automatic logic [1:0] draw_wait();
    logic [1:0] n;
    for (int k = 0; k < 2; k++) begin
      n[k] = lfsr[0];
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return n;
  endfunction

  initial begin
    ibus_ack   <= 1'b0;
    ibus_dat_r <= '0;
    dbus_ack   <= 1'b0;
    dbus_dat_r <= '0;
  end

  always @(posedge clk) begin
    if (reset) begin
      ibus_ack  <= 1'b0;
      dbus_ack  <= 1'b0;
      i_busy    <= 1'b0;
      d_busy    <= 1'b0;
      log_count <= 0;
    end else begin
      ibus_ack <= 1'b0;
      dbus_ack <= 1'b0;
      // instruction port, read only
      if (ibus_cyc && ibus_stb && !ibus_ack) begin
        if (!i_busy) begin
          i_busy <= 1'b1;
          i_wait <= draw_wait();
        end else if (i_wait != 2'd0) begin
          i_wait <= i_wait - 2'd1;
        end else begin
          i_busy     <= 1'b0;
          ibus_ack   <= 1'b1;
          ibus_dat_r <= mem[ibus_adr[8:2]];
        end
      end
      if (dbus_cyc && dbus_stb && !dbus_ack) begin
        if (!d_busy) begin
          d_busy <= 1'b1;
          d_wait <= draw_wait();
        end else if (d_wait != 2'd0) begin
          d_wait <= d_wait - 2'd1;
        end else begin
          d_busy     <= 1'b0;
          dbus_ack   <= 1'b1;
          dbus_dat_r <= mem[dbus_adr[8:2]];
          if (dbus_we) begin
            for (int b = 0; b < 4; b++) begin
              if (dbus_sel[b]) begin
                mem[dbus_adr[8:2]][8*b +: 8] <= dbus_dat_w[8*b +: 8];
              end
            end
            log_adr[log_count] <= dbus_adr;  // write log read by the testbench
            log_dat[log_count] <= dbus_dat_w;
            log_sel[log_count] <= dbus_sel;
            log_count          <= log_count + 1;
          end
        end
      end
    end
  end

endmodule

//--- rtl/rv32_core.sv
`timescale 1ns/1ps

module rv32_core (
  input  logic                     clk,
  input  logic                     reset,
  // instruction bus, read only
  output logic                     ibus_cyc,
  output logic                     ibus_stb,
  output logic [rv_pkg::XLEN-1:0]  ibus_adr,
  input  logic [rv_pkg::XLEN-1:0]  ibus_dat_r,
  input  logic                     ibus_ack,
  // data bus
  output logic                     dbus_cyc,
  output logic                     dbus_stb,
  output logic                     dbus_we,
  output logic [rv_pkg::XLEN-1:0]  dbus_adr,
  output logic [rv_pkg::SEL_W-1:0] dbus_sel,
  output logic [rv_pkg::XLEN-1:0]  dbus_dat_w,
  input  logic [rv_pkg::XLEN-1:0]  dbus_dat_r,
  input  logic                     dbus_ack,
  output logic [rv_pkg::XLEN-1:0]  pc,
  output logic                     halt
);

  rv_pkg::inst_t           inst;
  logic                    inst_valid;
  logic                    retire;
  logic [rv_pkg::XLEN-1:0] next_pc;
  logic                    mem_start;
  logic                    mem_we;
  logic [2:0]              mem_size;
  logic [rv_pkg::XLEN-1:0] mem_addr;
  logic [rv_pkg::XLEN-1:0] store_data;
  logic                    mem_done;
  logic [rv_pkg::XLEN-1:0] load_data;

  fetch_unit i_fetch_unit (
    .clk        (clk),
    .reset      (reset),
    .halt       (halt),
    .retire     (retire),
    .next_pc    (next_pc),
    .ibus_cyc   (ibus_cyc),
    .ibus_stb   (ibus_stb),
    .ibus_adr   (ibus_adr),
    .ibus_dat_r (ibus_dat_r),
    .ibus_ack   (ibus_ack),
    .inst       (inst),
    .inst_pc    (pc),
    .inst_valid (inst_valid)
  );

  execute_unit i_execute_unit (
    .clk        (clk),
    .reset      (reset),
    .inst       (inst),
    .inst_pc    (pc),
    .inst_valid (inst_valid),
    .retire     (retire),
    .next_pc    (next_pc),
    .halt       (halt),
    .mem_start  (mem_start),
    .mem_we     (mem_we),
    .mem_size   (mem_size),
    .mem_addr   (mem_addr),
    .store_data (store_data),
    .mem_done   (mem_done),
    .load_data  (load_data)
  );

  load_store_unit i_load_store_unit (
    .clk        (clk),
    .reset      (reset),
    .mem_start  (mem_start),
    .mem_we     (mem_we),
    .mem_size   (mem_size),
    .mem_addr   (mem_addr),
    .store_data (store_data),
    .mem_done   (mem_done),
    .load_data  (load_data),
    .dbus_cyc   (dbus_cyc),
    .dbus_stb   (dbus_stb),
    .dbus_we    (dbus_we),
    .dbus_adr   (dbus_adr),
    .dbus_sel   (dbus_sel),
    .dbus_dat_w (dbus_dat_w),
    .dbus_dat_r (dbus_dat_r),
    .dbus_ack   (dbus_ack)
  );

endmodule

//--- rtl/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     mem_start,
  input  logic                     mem_we,
  input  logic [2:0]               mem_size,
  input  logic [rv_pkg::XLEN-1:0]  mem_addr,
  input  logic [rv_pkg::XLEN-1:0]  store_data,
  output logic                     mem_done,
  output logic [rv_pkg::XLEN-1:0]  load_data,
  output logic                     dbus_cyc,
  output logic                     dbus_stb,
  output logic                     dbus_we,
  output logic [rv_pkg::XLEN-1:0]  dbus_adr,
  output logic [rv_pkg::SEL_W-1:0] dbus_sel,
  output logic [rv_pkg::XLEN-1:0]  dbus_dat_w,
  input  logic [rv_pkg::XLEN-1:0]  dbus_dat_r,
  input  logic                     dbus_ack
);

  logic                    busy;
  logic                    we_q;
  logic [2:0]              size_q;
  logic [rv_pkg::XLEN-1:0] addr_q;
  logic [rv_pkg::XLEN-1:0] data_q;
  logic [1:0]              offset;  // byte lane after alignment
  logic [rv_pkg::XLEN-1:0] lane;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      we_q <= 1'b0;
    end else if (mem_start) begin
      busy <= 1'b1;
      we_q <= mem_we;
    end else if (busy && dbus_ack) begin
      busy <= 1'b0;
    end
  end

  // request payload
  always_ff @(posedge clk) begin
    if (mem_start) begin
      size_q <= mem_size;
      addr_q <= mem_addr;
      data_q <= store_data;
    end
  end

  // low address bits below the access size are dropped
  always_comb begin
    case (size_q)
      rv_pkg::F3_BYTE, rv_pkg::F3_BYTE_U: begin
        offset     = addr_q[1:0];
        dbus_sel   = 4'b0001 << addr_q[1:0];
        dbus_dat_w = {4{data_q[7:0]}};
      end
      rv_pkg::F3_HALF, rv_pkg::F3_HALF_U: begin
        offset     = {addr_q[1], 1'b0};
        dbus_sel   = addr_q[1] ? 4'b1100 : 4'b0011;
        dbus_dat_w = {2{data_q[15:0]}};
      end
      default: begin  // word
        offset     = 2'b00;
        dbus_sel   = 4'b1111;
        dbus_dat_w = data_q;
      end
    endcase
  end

  assign lane = dbus_dat_r >> {offset, 3'b000};

  always_comb begin
    case (size_q)
      rv_pkg::F3_BYTE:   load_data = {{24{lane[7]}}, lane[7:0]};
      rv_pkg::F3_BYTE_U: load_data = {24'h000000, lane[7:0]};
      rv_pkg::F3_HALF:   load_data = {{16{lane[15]}}, lane[15:0]};
      rv_pkg::F3_HALF_U: load_data = {16'h0000, lane[15:0]};
      default:           load_data = lane;
    endcase
  end

  assign mem_done = busy && dbus_ack;
  assign dbus_cyc = busy;
  assign dbus_stb = busy;
  assign dbus_we  = we_q;
  assign dbus_adr = {addr_q[rv_pkg::XLEN-1:2], 2'b00};

endmodule

//--- rtl/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
  input  logic                    clk,
  input  logic                    reset,
  input  rv_pkg::inst_t           inst,
  input  logic [rv_pkg::XLEN-1:0] inst_pc,
  input  logic                    inst_valid,
  output logic                    retire,
  output logic [rv_pkg::XLEN-1:0] next_pc,
  output logic                    halt,
  output logic                    mem_start,
  output logic                    mem_we,
  output logic [2:0]              mem_size,
  output logic [rv_pkg::XLEN-1:0] mem_addr,
  output logic [rv_pkg::XLEN-1:0] store_data,
  input  logic                    mem_done,
  input  logic [rv_pkg::XLEN-1:0] load_data
);

  logic [6:0]              opcode;
  logic [rv_pkg::XLEN-1:0] imm_i;
  logic [rv_pkg::XLEN-1:0] imm_s;
  logic [rv_pkg::XLEN-1:0] imm_u;
  logic [rv_pkg::XLEN-1:0] imm_j;
  logic [rv_pkg::XLEN-1:0] rs1_data;
  logic [rv_pkg::XLEN-1:0] rs2_data;
  logic [rv_pkg::XLEN-1:0] op_a;
  logic [rv_pkg::XLEN-1:0] op_b;
  logic [rv_pkg::XLEN-1:0] sum;
  logic [rv_pkg::XLEN-1:0] pc_plus4;
  logic [rv_pkg::XLEN-1:0] wb_data;
  logic                    is_load;
  logic                    is_store;
  logic                    is_mem;
  logic                    is_ebreak;
  logic                    writes_rd;  // writes in the inst_valid cycle
  logic                    rf_wen;

  assign opcode = inst.i.opcode;

  // sign-extended immediates, one per format
  assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
  assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
  assign imm_u = {inst.u.imm, 12'h000};
  assign imm_j = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                  inst.j.imm_11, inst.j.imm_10_1, 1'b0};

  assign is_load   = (opcode == rv_pkg::OPC_LOAD);
  assign is_store  = (opcode == rv_pkg::OPC_STORE);
  assign is_mem    = is_load || is_store;
  assign is_ebreak = (opcode == rv_pkg::OPC_SYSTEM) && (inst.i.imm == 12'h001);

  // one shared adder, operands picked by opcode
  always_comb begin
    op_a      = rs1_data;
    op_b      = imm_i;
    writes_rd = 1'b0;
    case (opcode)
      rv_pkg::OPC_OP_IMM: writes_rd = 1'b1;  // every funct3 treated as addi
      rv_pkg::OPC_LUI: begin
        op_a      = '0;
        op_b      = imm_u;
        writes_rd = 1'b1;
      end
      rv_pkg::OPC_AUIPC: begin
        op_a      = inst_pc;
        op_b      = imm_u;
        writes_rd = 1'b1;
      end
      rv_pkg::OPC_JAL: begin
        op_a      = inst_pc;
        op_b      = imm_j;
        writes_rd = 1'b1;
      end
      rv_pkg::OPC_JALR: writes_rd = 1'b1;
      rv_pkg::OPC_STORE: op_b = imm_s;
      default: ;  // load keeps rs1 + imm_i, the rest are no-ops
    endcase
  end

  assign sum      = op_a + op_b;
  assign pc_plus4 = inst_pc + 32'd4;

  always_comb begin
    case (opcode)
      rv_pkg::OPC_JAL:  next_pc = sum;
      rv_pkg::OPC_JALR: next_pc = {sum[rv_pkg::XLEN-1:1], 1'b0};
      default:          next_pc = pc_plus4;
    endcase
  end

  always_comb begin
    if ((opcode == rv_pkg::OPC_JAL) || (opcode == rv_pkg::OPC_JALR)) begin
      wb_data = pc_plus4;  // link address
    end else if (is_load) begin
      wb_data = load_data;
    end else begin
      wb_data = sum;
    end
  end

  assign rf_wen = (inst_valid && writes_rd) || (mem_done && is_load);

  register_file i_register_file (
    .clk      (clk),
    .rs1      (inst.i.rs1),
    .rs2      (inst.s.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wen      (rf_wen),
    .rd       (inst.i.rd),
    .wdata    (wb_data)
  );

  // memory ops finish on mem_done, ebreak never finishes
  assign retire = (inst_valid && !is_mem && !is_ebreak) || mem_done;

  assign mem_start  = inst_valid && is_mem;
  assign mem_we     = is_store;
  assign mem_size   = inst.i.funct3;
  assign mem_addr   = sum;
  assign store_data = rs2_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      halt <= 1'b0;
    end else if (inst_valid && is_ebreak) begin
      halt <= 1'b1;  // sticky
    end
  end

endmodule

//--- rtl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    halt,
  input  logic                    retire,
  input  logic [rv_pkg::XLEN-1:0] next_pc,
  output logic                    ibus_cyc,
  output logic                    ibus_stb,
  output logic [rv_pkg::XLEN-1:0] ibus_adr,
  input  logic [rv_pkg::XLEN-1:0] ibus_dat_r,
  input  logic                    ibus_ack,
  output rv_pkg::inst_t           inst,
  output logic [rv_pkg::XLEN-1:0] inst_pc,
  output logic                    inst_valid
);

  logic [rv_pkg::XLEN-1:0] pc_q;
  logic                    wait_retire;  // low while requesting, high while execute owns inst
  logic                    cyc_q;
  logic                    fetch_done;

  assign fetch_done = !wait_retire && cyc_q && ibus_ack;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q        <= rv_pkg::RESET_PC;
      wait_retire <= 1'b0;
      cyc_q       <= 1'b0;
      inst_valid  <= 1'b0;
    end else begin
      inst_valid <= 1'b0;
      if (!wait_retire) begin
        if (fetch_done) begin
          cyc_q       <= 1'b0;
          wait_retire <= 1'b1;
          inst_valid  <= 1'b1;
        end else if (!cyc_q && !halt) begin
          cyc_q <= 1'b1;  // only taken right after reset
        end
      end else if (retire) begin
        pc_q        <= next_pc;
        wait_retire <= 1'b0;
        cyc_q       <= !halt;  // next request goes out straight away
      end
    end
  end

  // captured word stays put until retire
  always_ff @(posedge clk) begin
    if (fetch_done) begin
      inst <= ibus_dat_r;
    end
  end

  assign ibus_cyc = cyc_q;
  assign ibus_stb = cyc_q;
  assign ibus_adr = pc_q;
  assign inst_pc  = pc_q;

endmodule

//--- rtl/register_file.sv
`timescale 1ns/1ps

module register_file (
  input  logic                          clk,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs1,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs2,
  output logic [rv_pkg::XLEN-1:0]       rs1_data,
  output logic [rv_pkg::XLEN-1:0]       rs2_data,
  input  logic                          wen,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rd,
  input  logic [rv_pkg::XLEN-1:0]       wdata
);

  logic [rv_pkg::XLEN-1:0] regs [0:(1 << rv_pkg::REG_ADDR_W)-1];

  // x0 never written
  always_ff @(posedge clk) begin
    if (wen && (rd != '0)) begin
      regs[rd] <= wdata;
    end
  end

  // asynchronous reads, x0 forced to zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- rtl/rv_pkg.sv
package rv_pkg;

  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned SEL_W      = 4;

  localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

  // major opcodes handled by the core
  localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
  localparam logic [6:0] OPC_LUI    = 7'b011_0111;
  localparam logic [6:0] OPC_AUIPC  = 7'b001_0111;
  localparam logic [6:0] OPC_JAL    = 7'b110_1111;
  localparam logic [6:0] OPC_JALR   = 7'b110_0111;
  localparam logic [6:0] OPC_LOAD   = 7'b000_0011;
  localparam logic [6:0] OPC_STORE  = 7'b010_0011;
  localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;

  // load/store width in funct3
  localparam logic [2:0] F3_BYTE   = 3'b000;
  localparam logic [2:0] F3_HALF   = 3'b001;
  localparam logic [2:0] F3_WORD   = 3'b010;
  localparam logic [2:0] F3_BYTE_U = 3'b100;
  localparam logic [2:0] F3_HALF_U = 3'b101;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } inst_i_t;

  typedef struct packed {
    logic [6:0] imm_hi;  // imm[11:5]
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;  // imm[4:0]
    logic [6:0] opcode;
  } inst_s_t;

  typedef struct packed {
    logic [19:0] imm;  // imm[31:12]
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } inst_u_t;

  // jal immediate bits are scattered over the upper word
  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } inst_j_t;

  typedef union packed {
    inst_i_t i;
    inst_s_t s;
    inst_u_t u;
    inst_j_t j;
  } inst_t;

endpackage
